// File: frameGen_defs.svh
`ifndef FRAMEGEN_DEFS_SVH
`define FRAMEGEN_DEFS_SVH

// data words in one frame, header and footer not counted
`define FRAME_LEN 8

// deepest pre-trigger delay in accepted beats
`define MAX_PRE 3

// data buffer holds two full frames
`define DATA_DEPTH 16

// info records waiting for the reader
`define INFO_DEPTH 4

// channel tag placed in every header
`define CHANNEL_ID 8'h03

// frame markers
`define HDR_MAGIC 8'hA5
`define FTR_MAGIC 8'h5A

`endif

// File: sampleTypesPkg.sv
`include "frameGen_defs.svh"

package sampleTypesPkg;

  // one adc sample slot, 16 bit container
  typedef logic [15:0] sampleT;

  // four samples packed per beat, sample 0 in the low bits
  typedef sampleT [3:0] dataT;

  // free running timestamp from the acquisition side
  typedef logic [47:0] tsT;

  // pre-trigger beat count, wide enough for MAX_PRE
  typedef logic [$clog2(`MAX_PRE + 1)-1:0] preLenT;

  // one input beat
  typedef struct packed {
    logic trig;  // trigger flag for this beat
    tsT   ts;    // timestamp of sample 0
    dataT data;  // packed samples
  } beatT;

endpackage

// File: frameFmtPkg.sv
package frameFmtPkg;

  // output stream word, also the data buffer payload
  typedef logic [63:0] wordT;

  typedef logic [7:0]  magicT;
  typedef logic [15:0] frameNumT;  // wraps after 65535 frames
  typedef logic [7:0]  dropCntT;   // saturates at 255

  // first word of every frame
  typedef struct packed {
    magicT       magic;     // HDR_MAGIC
    logic [7:0]  channel;
    frameNumT    frameNum;
    logic [23:0] firstTs;   // low bits of first data word ts
    dropCntT     dropCnt;   // triggers lost since last frame
  } headerT;

  // last word of every frame
  typedef struct packed {
    sampleTypesPkg::tsT trigTs;  // ts of the trigger beat itself
    magicT              magic;   // FTR_MAGIC
    logic [7:0]         preLen;  // zero extended
  } footerT;

  // one info buffer entry per accepted trigger
  typedef struct packed {
    headerT hdr;
    footerT ftr;
  } infoT;

endpackage

// File: fifoIf.sv
`timescale 1ns/1ps

interface fifoIf #(
  parameter type payloadT = logic,
  parameter int  DEPTH    = 4
);

  localparam int CNT_W = $clog2(DEPTH + 1);

  // write side
  payloadT          wdata;
  logic             we;
  logic             full;
  logic [CNT_W-1:0] freeSlots;  // room left, used for input ready

  // read side
  payloadT          rdata;       // head entry, valid while empty is low
  logic             re;          // pop
  logic             empty;

  modport writer (
    output wdata,
    output we,
    input  full,
    input  freeSlots
  );

  modport fifo (
    input  wdata,
    input  we,
    output full,
    output freeSlots,
    output rdata,
    input  re,
    output empty
  );

  modport reader (
    input  rdata,
    input  empty,
    output re
  );

endinterface

// File: frameFifo.sv
`timescale 1ns/1ps

module frameFifo #(
  parameter type payloadT = logic,
  parameter int  DEPTH    = 4
) (
  input logic WR_CLK,
  input logic RD_RESET,
  fifoIf.fifo port
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payloadT          mem [DEPTH];
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [CNT_W-1:0] count;     // entries held
  logic             doWrite;
  logic             doRead;

  assign port.full      = (count == CNT_W'(DEPTH));
  assign port.empty     = (count == '0);
  assign port.freeSlots = CNT_W'(DEPTH) - count;
  assign port.rdata     = mem[rdPtr];  // fall through, head always on the bus

  // requests outside the legal range are dropped
  assign doWrite = port.we & ~port.full;
  assign doRead  = port.re & ~port.empty;

  always_ff @(posedge WR_CLK) begin
    if (doWrite) begin
      mem[wrPtr] <= port.wdata;
    end
  end

  always_ff @(posedge WR_CLK) begin
    if (RD_RESET) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doWrite) begin
        wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;  // wrap
      end
      if (doRead) begin
        rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      end
      case ({doWrite, doRead})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

endmodule

// File: frameWriter.sv
`timescale 1ns/1ps
`include "frameGen_defs.svh"

module frameWriter (
  input  logic                   WR_CLK,
  input  logic                   RD_RESET,
  input  logic                   iValid,
  output logic                   oReady,
  input  sampleTypesPkg::beatT   din,
  input  sampleTypesPkg::preLenT preLen,
  fifoIf.writer                  dataBus,
  fifoIf.writer                  infoBus
);

  localparam int CNT_W = $clog2(`FRAME_LEN + 1);

  sampleTypesPkg::beatT   dlyLine [`MAX_PRE];  // [0] is the newest past beat
  sampleTypesPkg::beatT   selBeat;             // beat at the chosen delay
  sampleTypesPkg::preLenT preLat;              // delay held for the frame
  sampleTypesPkg::preLenT selPre;
  frameFmtPkg::wordT      wordReg;             // staged data word
  frameFmtPkg::infoT      infoRec;
  frameFmtPkg::frameNumT  frameCnt;
  frameFmtPkg::dropCntT   dropCnt;
  logic [CNT_W-1:0]       wordCnt;             // words taken this frame
  logic                   started;             // first cycle out of reset done
  logic                   capturing;
  logic                   weReg;
  logic                   accept;
  logic                   startCap;
  logic                   takeWord;

  // need two free data slots since one staged write may still be in flight
  assign oReady   = started & ((dataBus.freeSlots >> 1) != '0) & ~infoBus.full;
  assign accept   = iValid & oReady;
  assign startCap = accept & din.trig & ~capturing;  // trigger while idle
  assign takeWord = accept & (capturing | startCap);

  // trigger beat uses the live preLen, later beats the latched one
  assign selPre  = capturing ? preLat : preLen;
  assign selBeat = (selPre == '0) ? din
                 : dlyLine[selPre - sampleTypesPkg::preLenT'(1)];

  always_comb begin
    infoRec.hdr.magic    = `HDR_MAGIC;
    infoRec.hdr.channel  = `CHANNEL_ID;
    infoRec.hdr.frameNum = frameCnt;
    infoRec.hdr.firstTs  = selBeat.ts[23:0];  // ts of word 0, not of the trigger
    infoRec.hdr.dropCnt  = dropCnt;
    infoRec.ftr.trigTs   = din.ts;
    infoRec.ftr.magic    = `FTR_MAGIC;
    infoRec.ftr.preLen   = 8'(preLen);
  end

  // delay line and word stage move only on accepted beats
  always_ff @(posedge WR_CLK) begin
    if (accept) begin
      dlyLine[0] <= din;
      for (int i = 1; i < `MAX_PRE; i++) begin
        dlyLine[i] <= dlyLine[i-1];
      end
    end
    if (takeWord) begin
      wordReg <= selBeat.data;
    end
  end

  always_ff @(posedge WR_CLK) begin
    if (RD_RESET) begin
      started   <= 1'b0;
      capturing <= 1'b0;
      weReg     <= 1'b0;
      preLat    <= '0;
      wordCnt   <= '0;
      frameCnt  <= '0;
      dropCnt   <= '0;
    end else begin
      started <= 1'b1;
      weReg   <= takeWord;  // data write lands one cycle after accept
      if (startCap) begin
        capturing <= 1'b1;
        preLat    <= preLen;
        wordCnt   <= CNT_W'(1);  // trigger beat already gave word 0
        frameCnt  <= frameCnt + 1'b1;
        dropCnt   <= '0;         // count reported in this record
      end else if (accept && capturing) begin
        wordCnt <= wordCnt + 1'b1;
        if (wordCnt == CNT_W'(`FRAME_LEN - 1)) begin
          capturing <= 1'b0;  // last word of frame
        end
        if (din.trig && dropCnt != 8'hFF) begin
          dropCnt <= dropCnt + 1'b1;  // lost trigger, saturating
        end
      end
    end
  end

  assign dataBus.wdata = wordReg;
  assign dataBus.we    = weReg;
  assign infoBus.wdata = infoRec;
  assign infoBus.we    = startCap;  // same edge as the trigger beat

endmodule

// File: frameReader.sv
`timescale 1ns/1ps
`include "frameGen_defs.svh"

module frameReader (
  input  logic              WR_CLK,
  input  logic              RD_RESET,
  fifoIf.reader             dataBus,
  fifoIf.reader             infoBus,
  output logic              oValid,
  input  logic              iReady,
  output frameFmtPkg::wordT dout
);

  localparam int CNT_W = $clog2(`FRAME_LEN + 1);

  typedef enum logic [1:0] {
    stIdle,
    stHdr,
    stData,
    stFtr
  } stateT;

  stateT             state;
  frameFmtPkg::infoT info;      // head record, stays put until footer goes out
  logic [CNT_W-1:0]  loadCnt;   // data words moved into dout
  logic              inBody;
  logic              slotFree;  // dout may take a new word this edge
  logic              bodyDone;
  logic              dataPop;

  assign info     = infoBus.rdata;
  assign inBody   = (state == stHdr) | (state == stData);
  assign slotFree = ~oValid | iReady;
  assign bodyDone = (loadCnt == CNT_W'(`FRAME_LEN));
  assign dataPop  = inBody & slotFree & ~bodyDone & ~dataBus.empty;

  assign dataBus.re = dataPop;
  assign infoBus.re = (state == stFtr) & oValid & iReady;  // footer accepted

  // output word register, held while iReady is low
  always_ff @(posedge WR_CLK) begin
    case (state)
      stIdle: begin
        if (!infoBus.empty) begin
          dout <= info.hdr;
        end
      end
      stHdr, stData: begin
        if (slotFree && bodyDone) begin
          dout <= info.ftr;
        end else if (dataPop) begin
          dout <= dataBus.rdata;
        end
      end
      default: dout <= dout;
    endcase
  end

  always_ff @(posedge WR_CLK) begin
    if (RD_RESET) begin
      state   <= stIdle;
      oValid  <= 1'b0;
      loadCnt <= '0;
    end else begin
      case (state)
        stIdle: begin
          if (!infoBus.empty) begin  // a frame has started upstream
            oValid  <= 1'b1;
            loadCnt <= '0;
            state   <= stHdr;
          end
        end
        stHdr, stData: begin
          if (slotFree) begin
            state <= stData;
            if (bodyDone) begin
              oValid <= 1'b1;
              state  <= stFtr;
            end else if (!dataBus.empty) begin
              oValid  <= 1'b1;
              loadCnt <= loadCnt + 1'b1;
            end else begin
              oValid <= 1'b0;  // writer still behind, bubble
            end
          end
        end
        stFtr: begin
          if (iReady) begin
            oValid <= 1'b0;
            state  <= stIdle;
          end
        end
        default: state <= stIdle;
      endcase
    end
  end

endmodule

// File: frameGenTop.sv
`timescale 1ns/1ps
`include "frameGen_defs.svh"

module frameGenTop (
  input  logic                   WR_CLK,
  input  logic                   RD_RESET,
  input  logic                   iValid,
  output logic                   oReady,
  input  sampleTypesPkg::beatT   din,
  input  sampleTypesPkg::preLenT preLen,
  output logic                   oValid,
  input  logic                   iReady,
  output frameFmtPkg::wordT      dout
);

  // data words and per-frame records travel separately
  fifoIf #(
    .payloadT (frameFmtPkg::wordT),
    .DEPTH    (`DATA_DEPTH)
  ) dataBus ();

  fifoIf #(
    .payloadT (frameFmtPkg::infoT),
    .DEPTH    (`INFO_DEPTH)
  ) infoBus ();

  frameWriter frameWriter_inst (
    .WR_CLK   (WR_CLK),
    .RD_RESET (RD_RESET),
    .iValid   (iValid),
    .oReady   (oReady),
    .din      (din),
    .preLen   (preLen),
    .dataBus  (dataBus),
    .infoBus  (infoBus)
  );

  frameFifo #(
    .payloadT (frameFmtPkg::wordT),
    .DEPTH    (`DATA_DEPTH)
  ) dataFifo_inst (
    .WR_CLK   (WR_CLK),
    .RD_RESET (RD_RESET),
    .port     (dataBus)
  );

  frameFifo #(
    .payloadT (frameFmtPkg::infoT),
    .DEPTH    (`INFO_DEPTH)
  ) infoFifo_inst (
    .WR_CLK   (WR_CLK),
    .RD_RESET (RD_RESET),
    .port     (infoBus)
  );

  frameReader frameReader_inst (
    .WR_CLK   (WR_CLK),
    .RD_RESET (RD_RESET),
    .dataBus  (dataBus),
    .infoBus  (infoBus),
    .oValid   (oValid),
    .iReady   (iReady),
    .dout     (dout)
  );

endmodule

// File: frameGenTb.sv
`timescale 1ns/1ps

module frameGenTb;

  logic                   WR_CLK;
  logic                   RD_RESET;
  logic                   iValid;
  logic                   oReady;
  sampleTypesPkg::beatT   din;
  sampleTypesPkg::preLenT preLen;
  logic                   oValid;
  logic                   iReady;
  frameFmtPkg::wordT      dout;

  // trace contents with one entry per line
  logic                   inValid [$];
  sampleTypesPkg::beatT   inBeat [$];
  sampleTypesPkg::preLenT inPre [$];
  frameFmtPkg::wordT      expQ [$];   // expected stream with the next word at the head

  int   cycles;    // posedges since time 0
  int   limit;     // timeout in cycles
  int   wordNum;   // index of next output word
  logic sawStall;  // oReady seen low in the stall window

  frameGenTop frameGenTop_inst (
    .WR_CLK   (WR_CLK),
    .RD_RESET (RD_RESET),
    .iValid   (iValid),
    .oReady   (oReady),
    .din      (din),
    .preLen   (preLen),
    .oValid   (oValid),
    .iReady   (iReady),
    .dout     (dout)
  );

  initial begin
    WR_CLK = 1'b0;
    forever #20 WR_CLK = ~WR_CLK;  // 40 ns period
  end

  task automatic stopRun(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic checkValue(input logic [63:0] got, input logic [63:0] exp,
                            input string what);
    if (got !== exp) begin
      stopRun($sformatf("error at %0t: %s is %h, expected %h",
                        $time, what, got, exp));
    end
  endtask

  // I lines hold input beats and E lines expected words, others skipped
  task automatic readTrace();
    int                   fd;
    int                   v;
    int                   t;
    int                   p;
    logic [47:0]          ts;
    logic [63:0]          d;
    sampleTypesPkg::beatT beat;
    string                line;
    fd = $fopen("frameGen_trace.txt", "r");
    if (fd == 0) begin
      stopRun("could not open frameGen_trace.txt for reading");
    end
    while ($fgets(line, fd) != 0) begin
      if ($sscanf(line, "I %h %h %h %h %h", v, t, p, ts, d) == 5) begin
        beat.trig = t[0];
        beat.ts   = ts;
        beat.data = d;
        inValid.push_back(v[0]);
        inBeat.push_back(beat);
        inPre.push_back(sampleTypesPkg::preLenT'(p));
      end else if ($sscanf(line, "E %h", d) == 1) begin
        expQ.push_back(d);
      end
    end
    $fclose(fd);
  endtask

  initial begin
    RD_RESET = 1'b1;
    iValid   = 1'b0;
    din      = '0;
    preLen   = '0;
    iReady   = 1'b0;
    cycles   = 0;
    wordNum  = 0;
    sawStall = 1'b0;
    readTrace();
    limit = 4 * (inBeat.size() + expQ.size()) + 200;
    repeat (8) @(posedge WR_CLK);
    @(negedge WR_CLK);
    checkValue(64'(oReady), 64'd0, "oReady during reset");
    RD_RESET = 1'b0;
    @(negedge WR_CLK);
    checkValue(64'(oReady), 64'd1, "oReady on the first cycle after reset");
    for (int i = 0; i < inBeat.size(); i++) begin
      iValid = inValid[i];
      din    = inBeat[i];
      preLen = inPre[i];
      while (iValid && !oReady) @(negedge WR_CLK);  // hold until writer takes it
      @(negedge WR_CLK);
    end
    iValid = 1'b0;
    while (expQ.size() != 0) @(negedge WR_CLK);
    repeat (20) @(negedge WR_CLK);  // room for a stray extra word
    checkValue(64'(sawStall), 64'd1, "low oReady seen during the long stall");
    $display(">>> PASS");
    $finish;
  end

  // back-pressure and output check on the falling edge
  initial begin
    void'($urandom(32'h6f4e_a2ff));
    forever begin
      @(negedge WR_CLK);
      if (cycles >= 30 && cycles < 90) begin
        iReady = 1'b0;  // long stall so the buffers fill up
        if (!oReady) begin
          sawStall = 1'b1;
        end
      end else begin
        iReady = ($urandom % 4) != 0;
      end
      if (!RD_RESET && oValid && iReady) begin
        if (expQ.size() == 0) begin
          stopRun("the DUT sent a word after the expected stream had ended");
        end else begin
          checkValue(dout, expQ.pop_front(), $sformatf("output word %0d", wordNum));
          wordNum++;
        end
      end
    end
  end

  always @(posedge WR_CLK) begin
    cycles++;
    if (cycles > limit) begin
      stopRun($sformatf("timeout, the run did not finish within %0d clock cycles", limit));
    end
  end

endmodule

// File: frameGen_trace.txt
# I valid trig preLen ts data : one input beat, fields in hex
# E word : one expected output word in hex, in stream order
I 1 1 0 000000ABC000 D0D0000000000000
I 1 0 0 000000ABC001 D0D0000000000001
I 1 0 0 000000ABC002 D0D0000000000002
I 0 0 0 000000000000 0000000000000000
I 1 1 0 000000ABC003 D0D0000000000003
I 1 0 0 000000ABC004 D0D0000000000004
I 1 1 0 000000ABC005 D0D0000000000005
I 1 0 0 000000ABC006 D0D0000000000006
I 1 0 0 000000ABC007 D0D0000000000007
I 1 1 1 000000ABC008 D0D0000000000008
I 1 0 1 000000ABC009 D0D0000000000009
I 1 0 1 000000ABC00A D0D000000000000A
I 1 0 1 000000ABC00B D0D000000000000B
I 1 1 1 000000ABC00C D0D000000000000C
I 1 0 1 000000ABC00D D0D000000000000D
I 1 0 1 000000ABC00E D0D000000000000E
I 1 0 1 000000ABC00F D0D000000000000F
I 1 1 2 000000ABC010 D0D0000000000010
I 1 0 2 000000ABC011 D0D0000000000011
I 0 0 2 000000000000 0000000000000000
I 1 0 2 000000ABC012 D0D0000000000012
I 1 0 2 000000ABC013 D0D0000000000013
I 1 0 2 000000ABC014 D0D0000000000014
I 1 0 2 000000ABC015 D0D0000000000015
I 1 0 2 000000ABC016 D0D0000000000016
I 1 0 2 000000ABC017 D0D0000000000017
I 1 1 3 000000ABC018 D0D0000000000018
I 1 0 3 000000ABC019 D0D0000000000019
I 1 0 3 000000ABC01A D0D000000000001A
I 1 0 3 000000ABC01B D0D000000000001B
I 1 0 3 000000ABC01C D0D000000000001C
I 1 0 3 000000ABC01D D0D000000000001D
I 1 0 3 000000ABC01E D0D000000000001E
I 1 0 3 000000ABC01F D0D000000000001F
E A5030000ABC00000
E D0D0000000000000
E D0D0000000000001
E D0D0000000000002
E D0D0000000000003
E D0D0000000000004
E D0D0000000000005
E D0D0000000000006
E D0D0000000000007
E 000000ABC0005A00
E A5030001ABC00702
E D0D0000000000007
E D0D0000000000008
E D0D0000000000009
E D0D000000000000A
E D0D000000000000B
E D0D000000000000C
E D0D000000000000D
E D0D000000000000E
E 000000ABC0085A01
E A5030002ABC00E01
E D0D000000000000E
E D0D000000000000F
E D0D0000000000010
E D0D0000000000011
E D0D0000000000012
E D0D0000000000013
E D0D0000000000014
E D0D0000000000015
E 000000ABC0105A02
E A5030003ABC01500
E D0D0000000000015
E D0D0000000000016
E D0D0000000000017
E D0D0000000000018
E D0D0000000000019
E D0D000000000001A
E D0D000000000001B
E D0D000000000001C
E 000000ABC0185A03

// File: filelist.f
+incdir+.
sampleTypesPkg.sv
frameFmtPkg.sv
fifoIf.sv
frameFifo.sv
frameWriter.sv
frameReader.sv
frameGenTop.sv
frameGenTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module frameGenTb -f filelist.f
result=$(./obj_dir/VframeGenTb 2>&1) || true
printf '%s\n' "$result"
if printf '%s\n' "$result" | grep -qx '>>> PASS'; then
  exit 0
else
  exit 1
fi
